// File: sim.f
src/uart_cmd_pkg.sv
src/uart_tx_byte.sv
src/uart_rx_byte.sv
src/uart_cmd_master.sv
src/uart_cmd_top.sv
testbench/uart_cmd_checker.sv
testbench/tb_uart_cmd.sv

// File: src/uart_cmd_master.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_master
  import uart_cmd_pkg::*;
#(
  // at least 3, the transmitter pipeline eats two of the idle cycles
  parameter int GAP_CYCLES   = 100,
  parameter int RESP_TIMEOUT = 50000
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [CMD_WIDTH-1:0] cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  output logic                 tx_start,
  output logic [DATA_BITS-1:0] tx_byte,
  input  logic                 tx_busy,
  output logic                 rx_enable,
  input  logic                 rx_start_seen,
  input  logic                 rx_done,
  input  logic [DATA_BITS-1:0] rx_byte,
  input  logic                 rx_frame_err,
  output logic [DATA_BITS-1:0] read_data,
  output logic                 read_vld,
  output logic                 read_err
);

  localparam int GAP_W = $clog2(GAP_CYCLES);
  localparam int TO_W  = $clog2(RESP_TIMEOUT);

  master_state_e        state;
  logic [CMD_WIDTH-1:0] cmd_reg;
  logic [GAP_W-1:0]     gap_cnt;
  logic [TO_W-1:0]      to_cnt;
  logic                 tx_idle;

  // tx_busy only rises the cycle after tx_start, so both must be low
  assign tx_idle = !tx_start && !tx_busy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= ST_IDLE;
      cmd_reg   <= '0;
      cmd_rdy   <= 1'b1;
      tx_start  <= 1'b0;
      tx_byte   <= '0;
      rx_enable <= 1'b0;
      gap_cnt   <= '0;
      to_cnt    <= '0;
      read_data <= '0;
      read_vld  <= 1'b0;
      read_err  <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_vld <= 1'b0;
      case (state)
        // cmd_rdy is high in both of these states
        ST_IDLE, ST_FINISH:
        begin
          if (cmd_vld)
          begin
            cmd_reg  <= cmd_in;
            cmd_rdy  <= 1'b0;
            tx_start <= 1'b1;
            tx_byte  <= cmd_in[CMD_WIDTH-1 -: DATA_BITS];
            state    <= ST_SEND_ADDR;
          end
          else
          begin
            state <= ST_IDLE;
          end
        end
        ST_SEND_ADDR:
        begin
          if (tx_idle)
          begin
            if (cmd_reg[WRITE_FLAG_BIT])
            begin
              gap_cnt <= GAP_W'(GAP_CYCLES - 3);
              state   <= ST_GAP;
            end
            else
            begin
              rx_enable <= 1'b1;
              to_cnt    <= '0;
              state     <= ST_WAIT_RESP;
            end
          end
        end
        ST_GAP:
        begin
          if (gap_cnt == '0)
          begin
            tx_start <= 1'b1;
            tx_byte  <= cmd_reg[DATA_BITS-1:0];
            state    <= ST_SEND_DATA;
          end
          else
          begin
            gap_cnt <= gap_cnt - 1'b1;
          end
        end
        ST_SEND_DATA:
        begin
          if (tx_idle)
          begin
            cmd_rdy <= 1'b1;
            state   <= ST_FINISH;
          end
        end
        ST_WAIT_RESP:
        begin
          if (rx_start_seen)
          begin
            state <= ST_RECV_RESP;
          end
          else if (to_cnt == TO_W'(RESP_TIMEOUT - 1))
          begin
            // nothing came back, report an empty byte with the error flag
            rx_enable <= 1'b0;
            read_data <= '0;
            read_err  <= 1'b1;
            read_vld  <= 1'b1;
            cmd_rdy   <= 1'b1;
            state     <= ST_FINISH;
          end
          else
          begin
            to_cnt <= to_cnt + 1'b1;
          end
        end
        ST_RECV_RESP:
        begin
          if (rx_done)
          begin
            rx_enable <= 1'b0;
            read_data <= rx_byte;
            read_err  <= rx_frame_err;
            read_vld  <= 1'b1;
            cmd_rdy   <= 1'b1;
            state     <= ST_FINISH;
          end
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/uart_cmd_pkg.sv
`default_nettype none

package uart_cmd_pkg;

  localparam int CMD_WIDTH = 16;
  localparam int WRITE_FLAG_BIT = 15;
  localparam int DATA_BITS = 8;

  // start bit, eight data bits, parity bit and stop bit
  localparam int FRAME_BITS = 11;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND_ADDR,
    ST_GAP,
    ST_SEND_DATA,
    ST_WAIT_RESP,
    ST_RECV_RESP,
    ST_FINISH
  } master_state_e;

  // the returned bit makes the count of ones in data plus parity odd
  function automatic logic odd_parity(input logic [DATA_BITS-1:0] data);
    return ~^data;
  endfunction

endpackage

`default_nettype wire

// File: src/uart_cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_top
  import uart_cmd_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434,
  parameter int GAP_CYCLES   = 100,
  parameter int RESP_TIMEOUT = 50000
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [CMD_WIDTH-1:0] cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  input  logic                 rx,
  output logic                 tx,
  output logic [DATA_BITS-1:0] read_data,
  output logic                 read_vld,
  output logic                 read_err
);

  logic                 tx_start;
  logic [DATA_BITS-1:0] tx_byte;
  logic                 tx_busy;
  logic                 rx_enable;
  logic                 rx_start_seen;
  logic                 rx_done;
  logic [DATA_BITS-1:0] rx_byte;
  logic                 rx_frame_err;

  uart_cmd_master #(
    .GAP_CYCLES   (GAP_CYCLES),
    .RESP_TIMEOUT (RESP_TIMEOUT)
  ) u_master (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_in        (cmd_in),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte),
    .tx_busy       (tx_busy),
    .rx_enable     (rx_enable),
    .rx_start_seen (rx_start_seen),
    .rx_done       (rx_done),
    .rx_byte       (rx_byte),
    .rx_frame_err  (rx_frame_err),
    .read_data     (read_data),
    .read_vld      (read_vld),
    .read_err      (read_err)
  );

  uart_tx_byte #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

  uart_rx_byte #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_rx (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rx_enable     (rx_enable),
    .rx_start_seen (rx_start_seen),
    .rx_done       (rx_done),
    .rx_byte       (rx_byte),
    .rx_frame_err  (rx_frame_err)
  );

endmodule

`default_nettype wire

// File: src/uart_rx_byte.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_byte
  import uart_cmd_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx,
  input  logic                 rx_enable,
  output logic                 rx_start_seen,
  output logic                 rx_done,
  output logic [DATA_BITS-1:0] rx_byte,
  output logic                 rx_frame_err
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int HALF  = CLKS_PER_BIT / 2;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_BITS,
    RX_END
  } rx_state_e;

  rx_state_e             state;
  logic                  rx_meta;
  logic                  rx_sync;
  logic                  rx_prev;
  logic [CNT_W-1:0]      clk_cnt;
  logic [3:0]            bit_idx;
  // data bits, then parity, then stop once all samples are in
  logic [FRAME_BITS-2:0] shreg;
  logic                  bit_end;
  logic                  half_end;
  logic                  sample;
  logic                  finish;

  assign bit_end  = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
  assign half_end = (clk_cnt == CNT_W'(HALF - 1));
  assign sample   = rx_enable && (state == RX_BITS) && bit_end;
  assign finish   = rx_enable && (state == RX_END) && half_end;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      shreg <= {rx_sync, shreg[FRAME_BITS-2:1]};
    end
    if (finish)
    begin
      rx_byte      <= shreg[DATA_BITS-1:0];
      rx_frame_err <= (shreg[DATA_BITS] != odd_parity(shreg[DATA_BITS-1:0])) ||
                      !shreg[DATA_BITS+1];
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= RX_IDLE;
      clk_cnt       <= '0;
      bit_idx       <= '0;
      rx_start_seen <= 1'b0;
      rx_done       <= 1'b0;
    end
    else
    begin
      rx_start_seen <= 1'b0;
      rx_done       <= 1'b0;
      if (!rx_enable)
      begin
        state   <= RX_IDLE;
        clk_cnt <= '0;
      end
      else
      begin
        case (state)
          RX_IDLE:
          begin
            if (rx_prev && !rx_sync)
            begin
              clk_cnt <= '0;
              state   <= RX_START;
            end
          end
          RX_START:
          begin
            if (half_end)
            begin
              clk_cnt <= '0;
              bit_idx <= '0;
              // a line that is high again at mid start bit was a glitch
              if (!rx_sync)
              begin
                rx_start_seen <= 1'b1;
                state         <= RX_BITS;
              end
              else
              begin
                state <= RX_IDLE;
              end
            end
            else
            begin
              clk_cnt <= clk_cnt + 1'b1;
            end
          end
          RX_BITS:
          begin
            if (bit_end)
            begin
              clk_cnt <= '0;
              bit_idx <= bit_idx + 4'd1;
              if (bit_idx == 4'(FRAME_BITS - 2))
              begin
                state <= RX_END;
              end
            end
            else
            begin
              clk_cnt <= clk_cnt + 1'b1;
            end
          end
          RX_END:
          begin
            // runs out the second half of the stop bit
            if (half_end)
            begin
              rx_done <= 1'b1;
              state   <= RX_IDLE;
            end
            else
            begin
              clk_cnt <= clk_cnt + 1'b1;
            end
          end
          default:
          begin
            state <= RX_IDLE;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: src/uart_tx_byte.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_byte
  import uart_cmd_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 tx_start,
  input  logic [DATA_BITS-1:0] tx_byte,
  output logic                 tx_busy,
  output logic                 tx
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);

  // everything after the start bit, sent from bit 0 upwards
  logic [FRAME_BITS-2:0] frame;
  logic [CNT_W-1:0]      clk_cnt;
  logic [3:0]            bit_idx;
  logic                  load;
  logic                  bit_end;

  assign load    = tx_start && !tx_busy;
  assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      frame <= {1'b1, odd_parity(tx_byte), tx_byte};
    end
  end

  // the start bit goes out in the same edge that loads the frame
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_busy <= 1'b0;
      tx      <= 1'b1;
      clk_cnt <= '0;
      bit_idx <= '0;
    end
    else if (load)
    begin
      tx_busy <= 1'b1;
      tx      <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
    end
    else if (tx_busy)
    begin
      if (bit_end)
      begin
        clk_cnt <= '0;
        if (bit_idx == 4'(FRAME_BITS - 1))
        begin
          // stop bit has run its full period
          tx_busy <= 1'b0;
          tx      <= 1'b1;
        end
        else
        begin
          tx      <= frame[bit_idx];
          bit_idx <= bit_idx + 4'd1;
        end
      end
      else
      begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_uart_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_cmd
  import uart_cmd_pkg::*;
#(
  parameter int CLKS_PER_BIT = 16,
  parameter int GAP_CYCLES   = 20,
  parameter int RESP_TIMEOUT = 600
) ();

  localparam int REPLY_DELAY = 40;
  localparam int WAIT_LIMIT  = 2000;
  localparam int NUM_RANDOM  = 30;
  localparam int NUM_TOTAL   = NUM_RANDOM + 4;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic [CMD_WIDTH-1:0] cmd_in;
  logic                 cmd_vld;
  logic                 cmd_rdy;
  logic                 rx;
  logic                 tx;
  logic [DATA_BITS-1:0] read_data;
  logic                 read_vld;
  logic                 read_err;
  logic [DATA_BITS-1:0] ref_byte;
  logic [31:0]          rng;
  logic [CMD_WIDTH-1:0] cur_cmd;
  logic                 timed_out;
  logic [DATA_BITS-1:0] model_mem [0:127];
  int                   errors;
  int                   checks;
  int                   accepted;
  int                   completed;
  int                   model_errors;
  int                   total_errors;

  // the remote device answers address a with a times 3 xor 0x5a in 8 bits
  function automatic logic [7:0] ref_reply(input logic [6:0] addr);
    logic [7:0] prod;
    prod = {1'b0, addr} * 8'd3;
    return prod ^ 8'h5A;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // addresses 0x7e and 0x7f are kept for the error cases
  function automatic logic [15:0] pick_cmd(input logic [31:0] r);
    logic [15:0] c;
    c = r[15:0];
    if (c[14:9] == 6'h3F)
      c[9] = 1'b0;
    return c;
  endfunction

  assign ref_byte = ref_reply(cmd_in[14:8]);

  always #4 clk = ~clk;

  uart_cmd_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .GAP_CYCLES   (GAP_CYCLES),
    .RESP_TIMEOUT (RESP_TIMEOUT)
  ) u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_vld  (read_vld),
    .read_err  (read_err)
  );

  uart_cmd_checker #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .GAP_CYCLES   (GAP_CYCLES)
  ) u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .read_data (read_data),
    .read_vld  (read_vld),
    .read_err  (read_err),
    .ref_byte  (ref_byte),
    .errors    (errors),
    .checks    (checks),
    .accepted  (accepted),
    .completed (completed)
  );

  task automatic note_timeout(input string what);
    timed_out = 1'b1;
    $display("timeout: no %s within %0d cycles", what, WAIT_LIMIT);
  endtask

  task automatic wait_tx_low();
    int n;
    n = 0;
    if (!timed_out)
    begin
      @(negedge clk);
      while (tx !== 1'b0 && n < WAIT_LIMIT)
      begin
        @(negedge clk);
        n++;
      end
      if (tx !== 1'b0)
        note_timeout("start bit on tx");
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    if (!timed_out)
    begin
      @(negedge clk);
      while (cmd_rdy !== 1'b1 && n < WAIT_LIMIT)
      begin
        @(negedge clk);
        n++;
      end
      if (cmd_rdy !== 1'b1)
        note_timeout("cmd_rdy");
      else
      begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  // returns just after the acceptance edge, cmd_vld still high
  task automatic present(input logic [15:0] cmd);
    if (!timed_out)
    begin
      cmd_in  = cmd;
      cmd_vld = 1'b1;
      wait_ready();
    end
  endtask

  // samples each bit of a tx frame in the middle of its period
  task automatic receive_tx_frame(output logic [7:0] data);
    logic [FRAME_BITS-2:0] bits;
    bits = '0;
    wait_tx_low();
    if (!timed_out)
    begin
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      for (int i = 0; i < FRAME_BITS - 1; i++)
      begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        bits[i] = tx;
      end
      @(posedge clk);
      #1;
    end
    data = bits[7:0];
  endtask

  task automatic send_rx_frame(input logic [7:0] data, input logic bad_parity);
    logic [FRAME_BITS-1:0] frame;
    logic                  par;
    par = ~(^data);
    if (bad_parity)
      par = ~par;
    frame = {1'b1, par, data, 1'b0};
    for (int i = 0; i < FRAME_BITS; i++)
    begin
      rx = frame[i];
      repeat (CLKS_PER_BIT) @(posedge clk);
      #1;
    end
  endtask

  // remote device: stores writes, answers reads except at 0x7e
  task automatic serve();
    logic [7:0] first;
    logic [7:0] second;
    receive_tx_frame(first);
    if (!timed_out && first[7])
    begin
      receive_tx_frame(second);
      model_mem[first[6:0]] = second;
    end
    else if (!timed_out && first[6:0] != 7'h7E)
    begin
      // rest of the stop bit, then the reply delay
      repeat (CLKS_PER_BIT / 2 - 1 + REPLY_DELAY) @(posedge clk);
      #1;
      send_rx_frame(ref_reply(first[6:0]), first[6:0] == 7'h7F);
    end
  endtask

  task automatic run_single(input string name, input logic [15:0] cmd);
    u_chk.test_name = name;
    present(cmd);
    cmd_vld = 1'b0;
    serve();
    wait_ready();
  endtask

  initial
  begin
    rst_n        = 1'b0;
    cmd_in       = '0;
    cmd_vld      = 1'b0;
    rx           = 1'b1;
    timed_out    = 1'b0;
    model_errors = 0;
    rng          = 32'h4595017e;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (5) @(posedge clk);
    #1;

    run_single("directed write", 16'h92A5);
    // the remote device must hold the data byte of the write at its address
    if (model_mem[7'h12] !== 8'hA5)
    begin
      $display("[FAIL] directed write, remote memory: expected a5, actual %0h",
               model_mem[7'h12]);
      model_errors++;
    end
    run_single("directed read", 16'h1200);
    run_single("bad parity read", 16'h7F00);
    run_single("timeout read", 16'h7E00);

    // back to back commands with cmd_vld held high throughout
    u_chk.test_name = "random commands";
    rng     = xorshift32(rng);
    cur_cmd = pick_cmd(rng);
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      present(cur_cmd);
      if (i == NUM_RANDOM - 1)
        cmd_vld = 1'b0;
      else
      begin
        rng     = xorshift32(rng);
        cur_cmd = pick_cmd(rng);
        cmd_in  = cur_cmd;
      end
      serve();
    end
    wait_ready();
    repeat (20) @(posedge clk);

    total_errors = errors + model_errors;
    if (timed_out)
      total_errors++;
    if (accepted != NUM_TOTAL)
    begin
      $display("expected %0d accepted commands but saw %0d", NUM_TOTAL, accepted);
      total_errors++;
    end
    if (completed != accepted)
    begin
      $display("%0d commands were accepted but %0d completed", accepted, completed);
      total_errors++;
    end
    $display("checks: %0d, errors: %0d", checks, total_errors);
    if (total_errors != 0)
      $display("Simulation failed");
    else
      $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/uart_cmd_checker.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_checker
  import uart_cmd_pkg::*;
#(
  parameter int CLKS_PER_BIT = 16,
  parameter int GAP_CYCLES   = 20
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [CMD_WIDTH-1:0] cmd_in,
  input  logic                 cmd_vld,
  input  logic                 cmd_rdy,
  input  logic                 tx,
  input  logic [DATA_BITS-1:0] read_data,
  input  logic                 read_vld,
  input  logic                 read_err,
  input  logic [DATA_BITS-1:0] ref_byte,
  output int                   errors,
  output int                   checks,
  output int                   accepted,
  output int                   completed
);

  localparam int FRAME_CLKS = FRAME_BITS * CLKS_PER_BIT;
  localparam int HALF_BIT   = CLKS_PER_BIT / 2;

  string                 test_name;
  logic                  busy;
  logic [CMD_WIDTH-1:0]  cur_cmd;
  logic [DATA_BITS-1:0]  cur_ref;
  // data bits, parity and stop, in line order
  logic [FRAME_BITS-2:0] bits;
  logic                  in_frame;
  logic [6:0]            addr;
  logic                  exp_err;
  logic [DATA_BITS-1:0]  exp_data;
  int                    frame_no;
  int                    bit_cnt;
  int                    cycle;
  int                    accept_cycle;
  int                    start_cycle;
  int                    prev_start;
  int                    rdy_wait;

  initial
  begin
    test_name = "reset";
    errors    = 0;
    checks    = 0;
    accepted  = 0;
    completed = 0;
    busy      = 1'b0;
    in_frame  = 1'b0;
    frame_no  = 0;
    bit_cnt   = 0;
    cycle     = 0;
    rdy_wait  = 0;
  end

  task automatic check_value(input string item, input logic [15:0] expected,
                             input logic [15:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("[FAIL] %s, %s: expected %0h, actual %0h", test_name, item, expected, actual);
    end
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("error in %s: %s", test_name, what);
  endtask

  task automatic check_frame();
    if (!busy)
      report_problem("a frame went out on tx with no command in flight");
    else
    begin
      // odd parity means the ones in data plus parity add up to an odd count
      check_value("odd parity", 16'd1, {15'd0, ^bits[DATA_BITS:0]});
      check_value("stop bit", 16'd1, {15'd0, bits[DATA_BITS+1]});
      if (frame_no == 0)
      begin
        check_value("address frame", {8'd0, cur_cmd[15:8]}, {8'd0, bits[7:0]});
        if (start_cycle - accept_cycle > 2)
          report_problem("the first start bit came more than 2 cycles after acceptance");
        frame_no = cur_cmd[15] ? 1 : 2;
      end
      else if (frame_no == 1)
      begin
        check_value("data frame", {8'd0, cur_cmd[7:0]}, {8'd0, bits[7:0]});
        check_value("start to start spacing", 16'(FRAME_CLKS + GAP_CYCLES),
                    16'(start_cycle - prev_start));
        frame_no = 2;
        rdy_wait = 2;
      end
      else
        report_problem("an extra frame went out on tx");
    end
    prev_start = start_cycle;
  endtask

  always @(negedge clk)
  begin
    cycle++;
    if (!rst_n)
    begin
      if (tx !== 1'b1 || cmd_rdy !== 1'b1 || read_vld !== 1'b0)
        report_problem("outputs are not at their reset values");
    end
    else
    begin
      // a write ends one cycle after the stop bit of its data frame
      if (rdy_wait == 2)
      begin
        check_value("cmd_rdy at stop end", 16'd0, {15'd0, cmd_rdy});
        rdy_wait = 1;
      end
      else if (rdy_wait == 1)
      begin
        check_value("cmd_rdy after write", 16'd1, {15'd0, cmd_rdy});
        rdy_wait  = 0;
        busy      = 1'b0;
        completed++;
      end

      if (read_vld === 1'b1)
      begin
        if (!busy || cur_cmd[15] || frame_no != 2)
          report_problem("read_vld came without a read in flight");
        else
        begin
          // 0x7e never gets a reply and 0x7f gets one with bad parity
          addr     = cur_cmd[14:8];
          exp_err  = (addr == 7'h7E) || (addr == 7'h7F);
          exp_data = (addr == 7'h7E) ? 8'h00 : cur_ref;
          check_value("read_data", {8'd0, exp_data}, {8'd0, read_data});
          check_value("read_err", {15'd0, exp_err}, {15'd0, read_err});
          check_value("cmd_rdy with read_vld", 16'd1, {15'd0, cmd_rdy});
          busy = 1'b0;
          completed++;
        end
      end

      if (cmd_vld === 1'b1 && cmd_rdy === 1'b1)
      begin
        if (busy)
          report_problem("a command was accepted while another was in flight");
        busy         = 1'b1;
        cur_cmd      = cmd_in;
        cur_ref      = ref_byte;
        accept_cycle = cycle;
        frame_no     = 0;
        accepted++;
      end

      if (in_frame)
      begin
        bit_cnt++;
        if (bit_cnt == HALF_BIT && tx !== 1'b0)
          report_problem("the start bit on tx was shorter than half a bit period");
        if (bit_cnt > HALF_BIT && (bit_cnt - HALF_BIT) % CLKS_PER_BIT == 0)
          bits = {tx, bits[FRAME_BITS-2:1]};
        if (bit_cnt == FRAME_CLKS - 1)
        begin
          in_frame = 1'b0;
          check_frame();
        end
      end
      else if (tx === 1'b0)
      begin
        in_frame    = 1'b1;
        bit_cnt     = 0;
        start_cycle = cycle;
      end

      if (!busy && cmd_rdy !== 1'b1)
        report_problem("cmd_rdy is low with no command in flight");
    end
  end

endmodule

`default_nettype wire
